//--- common/mem_pkg.sv
package mem_pkg;

   // word and byte widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // sram size as a byte address width
   localparam int SRAM_ADDR_W = 12;
   localparam int SRAM_WORDS = 2 ** (SRAM_ADDR_W - 2);

   // boot image size as a byte address width
   localparam int BOOTROM_ADDR_W = 6;
   localparam int BOOT_WORDS = 2 ** (BOOTROM_ADDR_W - 2);

   // boot region sits at the top of the sram, in words
   localparam int BOOT_OFFSET = SRAM_WORDS - BOOT_WORDS;
   localparam logic [ADDR_W-1:0] BOOT_BYTE_OFFSET = ADDR_W'(BOOT_OFFSET * 4);

   // data address bit that selects the boot control register
   localparam int BOOT_SEL_BIT = 31;

   // boot image, path from the run directory
   localparam string BOOT_HEX = "hw/boot/boot.hex";

   // request: valid is held until ready comes back
   // any strobe set makes it a write
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } bus_req_t;

   // response: ready is a one cycle pulse with the read data
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } bus_resp_t;

endpackage

//--- hw/int_sram.sv
`timescale 1ns/1ps

module int_sram import mem_pkg::*; (
   input  logic      clk,
   input  bus_req_t  i_ireq,
   input  bus_req_t  i_dreq,
   output bus_resp_t o_iresp,
   output bus_resp_t o_dresp
);

   localparam int IDX_W = SRAM_ADDR_W - 2;

   logic [DATA_W-1:0] mem [0:SRAM_WORDS-1];
   bus_req_t          req [2];
   logic [DATA_W-1:0] rdata_q [2];
   logic [1:0]        ready_q;

   // port 0 instruction, port 1 data
   assign req[0] = i_ireq;
   assign req[1] = i_dreq;

   // the data port is handled last, so it wins a same-word write
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (req[p].valid) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (req[p].wstrb[b]) begin
                  mem[req[p].addr[IDX_W+1:2]][b*8 +: 8] <= req[p].wdata[b*8 +: 8];
               end
            end
         end
      end
   end

   // read data is the word before any write on the same edge
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         rdata_q[p] <= mem[req[p].addr[IDX_W+1:2]];
      end
   end

   // ready one cycle after valid, on each port
   always_ff @(posedge clk) begin
      ready_q <= {i_dreq.valid, i_ireq.valid};
   end

   assign o_iresp.rdata = rdata_q[0];
   assign o_iresp.ready = ready_q[0];
   assign o_dresp.rdata = rdata_q[1];
   assign o_dresp.ready = ready_q[1];

endmodule

//--- hw/bus_split.sv
`timescale 1ns/1ps

module bus_split import mem_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  bus_req_t  i_mreq,
   output bus_resp_t o_mresp,
   output bus_req_t  o_sreq0,
   output bus_req_t  o_sreq1,
   input  bus_resp_t i_sresp0,
   input  bus_resp_t i_sresp1
);

   logic sel;
   logic sel_q;
   logic pending;
   logic issue;

   assign sel = i_mreq.addr[BOOT_SEL_BIT];

   // valid goes out once per transfer, the master keeps it up until ready
   assign issue = i_mreq.valid & ~pending;

   always_comb begin
      o_sreq0 = i_mreq;
      o_sreq1 = i_mreq;
      o_sreq0.valid = issue & ~sel;
      o_sreq1.valid = issue & sel;
   end

   assign o_mresp = sel_q ? i_sresp1 : i_sresp0;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pending <= 1'b0;
         sel_q <= 1'b0;
      end else if (issue) begin
         pending <= 1'b1;
         sel_q <= sel;
      end else if (o_mresp.ready) begin
         pending <= 1'b0;
      end
   end

endmodule

//--- hw/bus_merge.sv
`timescale 1ns/1ps

module bus_merge import mem_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  bus_req_t  i_mreq0,
   input  bus_req_t  i_mreq1,
   output bus_resp_t o_mresp0,
   output bus_resp_t o_mresp1,
   output bus_req_t  o_sreq,
   input  bus_resp_t i_sresp
);

   logic busy;
   logic gnt_q;
   logic sel;
   logic issue;

   // master 1 wins when both ask on an idle port
   assign sel = busy ? gnt_q : i_mreq1.valid;
   assign issue = ~busy & (i_mreq0.valid | i_mreq1.valid);

   always_comb begin
      o_sreq = sel ? i_mreq1 : i_mreq0;
      o_sreq.valid = issue;
   end

   // grant stays locked until the slave answers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy <= 1'b0;
         gnt_q <= 1'b0;
      end else if (issue) begin
         busy <= 1'b1;
         gnt_q <= i_mreq1.valid;
      end else if (i_sresp.ready) begin
         busy <= 1'b0;
      end
   end

   // only the granted master sees ready
   always_comb begin
      o_mresp0 = i_sresp;
      o_mresp1 = i_sresp;
      o_mresp0.ready = i_sresp.ready & busy & ~gnt_q;
      o_mresp1.ready = i_sresp.ready & busy & gnt_q;
   end

endmodule

//--- hw/boot/boot_ctr.sv
`timescale 1ns/1ps

module boot_ctr import mem_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  bus_req_t  i_creq,
   output bus_resp_t o_cresp,
   output bus_req_t  o_wreq,
   input  bus_resp_t i_wresp,
   output logic      o_boot,
   output logic      o_cpu_reset
);

   localparam int CNT_W = $clog2(BOOT_WORDS);

   logic [DATA_W-1:0] rom [0:BOOT_WORDS-1];
   logic [CNT_W-1:0]  cnt;
   logic              started;
   logic              done;
   logic              last_ack;
   logic              ctrl_wr;

   initial begin
      $readmemh(BOOT_HEX, rom);
   end

   // copy stream, one image word per request
   assign o_wreq.valid = started & ~done;
   assign o_wreq.addr = BOOT_BYTE_OFFSET + ADDR_W'({cnt, 2'b00});
   assign o_wreq.wdata = rom[cnt];
   assign o_wreq.wstrb = '1;

   assign last_ack = o_wreq.valid & i_wresp.ready & (cnt == CNT_W'(BOOT_WORDS - 1));

   // register write with bit 0 set ends boot
   assign ctrl_wr = i_creq.valid & (|i_creq.wstrb) & i_creq.wdata[0];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         started <= 1'b0;
         done <= 1'b0;
         cnt <= '0;
      end else begin
         started <= 1'b1;
         if (o_wreq.valid && i_wresp.ready) begin
            if (last_ack) begin
               done <= 1'b1;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_boot <= 1'b1;
         o_cpu_reset <= 1'b1;
      end else if (ctrl_wr) begin
         // processor restarts from the unshifted map
         o_boot <= 1'b0;
         o_cpu_reset <= 1'b1;
      end else if (done || last_ack) begin
         o_cpu_reset <= 1'b0;
      end
   end

   // control register reads back the boot flag
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_cresp.ready <= 1'b0;
      end else begin
         o_cresp.ready <= i_creq.valid;
      end
   end

   always_ff @(posedge clk) begin
      o_cresp.rdata <= {{(DATA_W-1){1'b0}}, o_boot};
   end

endmodule

//--- hw/int_mem.sv
`timescale 1ns/1ps

module int_mem import mem_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  bus_req_t  i_ireq,
   output bus_resp_t o_iresp,
   input  bus_req_t  i_dreq,
   output bus_resp_t o_dresp,
   output logic      o_boot,
   output logic      o_cpu_reset
);

   bus_req_t  split_req;
   bus_req_t  sram_dreq;
   bus_resp_t sram_dresp;
   bus_req_t  ctr_req;
   bus_resp_t ctr_resp;
   bus_req_t  fetch_req;
   bus_req_t  boot_wreq;
   bus_resp_t boot_wresp;
   bus_req_t  sram_ireq;
   bus_resp_t sram_iresp;

   // data bus goes to the sram or the boot control register
   bus_split data_split (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_mreq   (i_dreq),
      .o_mresp  (o_dresp),
      .o_sreq0  (split_req),
      .o_sreq1  (ctr_req),
      .i_sresp0 (sram_dresp),
      .i_sresp1 (ctr_resp)
   );

   boot_ctr boot_ctr_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_creq      (ctr_req),
      .o_cresp     (ctr_resp),
      .o_wreq      (boot_wreq),
      .i_wresp     (boot_wresp),
      .o_boot      (o_boot),
      .o_cpu_reset (o_cpu_reset)
   );

   // while booting, both buses run out of the top region
   always_comb begin
      fetch_req = i_ireq;
      sram_dreq = split_req;
      if (o_boot) begin
         fetch_req.addr = i_ireq.addr + BOOT_BYTE_OFFSET;
         sram_dreq.addr = split_req.addr + BOOT_BYTE_OFFSET;
      end
   end

   // boot copy and fetches share the instruction port
   bus_merge ibus_merge (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_mreq0  (fetch_req),
      .i_mreq1  (boot_wreq),
      .o_mresp0 (o_iresp),
      .o_mresp1 (boot_wresp),
      .o_sreq   (sram_ireq),
      .i_sresp  (sram_iresp)
   );

   int_sram sram_inst (
      .clk     (clk),
      .i_ireq  (sram_ireq),
      .i_dreq  (sram_dreq),
      .o_iresp (sram_iresp),
      .o_dresp (sram_dresp)
   );

endmodule

//--- verif/int_mem_assert.sv
`timescale 1ns/1ps

module int_mem_assert import mem_pkg::*; (
   input logic      clk,
   input logic      i_rst,
   input bus_req_t  i_ireq,
   input bus_resp_t i_iresp,
   input bus_req_t  i_dreq,
   input bus_resp_t i_dresp,
   input bus_req_t  i_sram_ireq,
   input bus_resp_t i_sram_iresp,
   input bus_req_t  i_sram_dreq,
   input bus_resp_t i_sram_dresp,
   input logic      i_boot
);

   int failures = 0;

   // a master only sees ready for a request it held on the edge before
   iresp_has_req: assert property (@(posedge clk) disable iff (i_rst)
      i_iresp.ready |-> $past(i_ireq.valid))
      else begin
         $error("instruction bus ready came without a held request");
         failures++;
      end

   dresp_has_req: assert property (@(posedge clk) disable iff (i_rst)
      i_dresp.ready |-> $past(i_dreq.valid))
      else begin
         $error("data bus ready came without a held request");
         failures++;
      end

   // each sram request is a one cycle pulse, answered on the next edge
   sram_i_latency: assert property (@(posedge clk) disable iff (i_rst)
      i_sram_ireq.valid |=> i_sram_iresp.ready && !i_sram_ireq.valid)
      else begin
         $error("sram instruction port request was not a single cycle answered one cycle later");
         failures++;
      end

   sram_d_latency: assert property (@(posedge clk) disable iff (i_rst)
      i_sram_dreq.valid |=> i_sram_dresp.ready && !i_sram_dreq.valid)
      else begin
         $error("sram data port request was not a single cycle answered one cycle later");
         failures++;
      end

   // once boot has ended only a reset brings it back
   boot_stays_low: assert property (@(posedge clk) disable iff (i_rst)
      !i_boot |=> !i_boot)
      else begin
         $error("o_boot rose again without a reset");
         failures++;
      end

endmodule

bind int_mem int_mem_assert assert_inst (
   .clk          (clk),
   .i_rst        (i_rst),
   .i_ireq       (i_ireq),
   .i_iresp      (o_iresp),
   .i_dreq       (i_dreq),
   .i_dresp      (o_dresp),
   .i_sram_ireq  (sram_ireq),
   .i_sram_iresp (sram_iresp),
   .i_sram_dreq  (sram_dreq),
   .i_sram_dresp (sram_dresp),
   .i_boot       (o_boot)
);

//--- verif/int_mem_checker.sv
`timescale 1ns/1ps

module int_mem_checker import mem_pkg::*; (
   input  logic      clk,
   input  logic      i_rst,
   input  bus_req_t  i_ireq,
   input  bus_resp_t i_iresp,
   input  bus_req_t  i_dreq,
   input  bus_resp_t i_dresp,
   input  logic      i_boot,
   output int        o_errors,
   output int        o_checks
);

   logic [DATA_W-1:0] image [0:BOOT_WORDS-1];
   logic [DATA_W-1:0] ref_mem [0:SRAM_WORDS-1];
   bus_req_t          held [2];
   logic              held_boot [2];
   logic [1:0]        pending;
   int                errors = 0;
   int                checks = 0;

   assign o_errors = errors;
   assign o_checks = checks;

   initial begin
      $readmemh(BOOT_HEX, image);
   end

   // sram word an address reaches, moved to the top region while booting
   function automatic int word_index(logic [ADDR_W-1:0] addr, logic boot);
      int idx;
      idx = int'((addr >> 2) % SRAM_WORDS);
      if (boot) begin
         idx = (idx + BOOT_OFFSET) % SRAM_WORDS;
      end
      return idx;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old, bus_req_t req);
      logic [DATA_W-1:0] word;
      word = old;
      for (int b = 0; b < STRB_W; b++) begin
         if (req.wstrb[b]) begin
            word[b*8 +: 8] = req.wdata[b*8 +: 8];
         end
      end
      return word;
   endfunction

   // reference read: boot flag for the register, else the model word
   function automatic logic [DATA_W-1:0] expected_read(bus_req_t req, logic boot);
      if (req.addr[BOOT_SEL_BIT]) begin
         return DATA_W'(boot);
      end
      return ref_mem[word_index(req.addr, boot)];
   endfunction

   task automatic watch_port(input int p, input bus_req_t req, input bus_resp_t resp,
                             input string name);
      logic [DATA_W-1:0] exp;
      int                idx;
      if (resp.ready && !pending[p]) begin
         errors++;
         $display("%s gave ready at %0t with no request outstanding", name, $time);
      end else if (resp.ready) begin
         pending[p] = 1'b0;
         if (held[p].wstrb == '0) begin
            exp = expected_read(held[p], held_boot[p]);
            checks++;
            if (resp.rdata !== exp) begin
               errors++;
               $display("error at %0t: %s.rdata expected %h got %h",
                        $time, name, exp, resp.rdata);
            end
         end else if (!held[p].addr[BOOT_SEL_BIT]) begin
            idx = word_index(held[p].addr, held_boot[p]);
            ref_mem[idx] = merge_bytes(ref_mem[idx], held[p]);
         end
      end
      if (req.valid && !pending[p]) begin
         held[p] = req;
         held_boot[p] = i_boot;
         pending[p] = 1'b1;
      end
   endtask

   always @(posedge clk) begin
      if (i_rst) begin
         pending = '0;
         // the copy engine puts the image in the top region
         for (int i = 0; i < BOOT_WORDS; i++) begin
            ref_mem[BOOT_OFFSET + i] = image[i];
         end
      end else begin
         watch_port(0, i_ireq, i_iresp, "o_iresp");
         watch_port(1, i_dreq, i_dresp, "o_dresp");
      end
   end

endmodule

//--- verif/int_mem_tb.sv
`timescale 1ns/1ps

module int_mem_tb import mem_pkg::*; ();

   localparam int TIMEOUT = 200;
   localparam int NUM_WR = 8;
   localparam logic [ADDR_W-1:0] CTRL_ADDR = 32'h8000_0000;

   logic              clk = 1'b0;
   logic              rst;
   bus_req_t          ireq;
   bus_resp_t         iresp;
   bus_req_t          dreq;
   bus_resp_t         dresp;
   bus_req_t          idle;
   logic              boot;
   logic              cpu_reset;
   int                chk_errors;
   int                chk_checks;
   int                tb_errors = 0;
   int                timeouts = 0;
   int                cycles;
   logic [ADDR_W-1:0] waddr [NUM_WR];

   always #50 clk = ~clk;

   int_mem int_mem_inst (
      .clk         (clk),
      .i_rst       (rst),
      .i_ireq      (ireq),
      .o_iresp     (iresp),
      .i_dreq      (dreq),
      .o_dresp     (dresp),
      .o_boot      (boot),
      .o_cpu_reset (cpu_reset)
   );

   int_mem_checker scoreboard (
      .clk      (clk),
      .i_rst    (rst),
      .i_ireq   (ireq),
      .i_iresp  (iresp),
      .i_dreq   (dreq),
      .i_dresp  (dresp),
      .i_boot   (boot),
      .o_errors (chk_errors),
      .o_checks (chk_checks)
   );

   task automatic finish_run();
      int errors;
      int asserts;
      errors = chk_errors + tb_errors;
      asserts = int_mem_inst.assert_inst.failures;
      $display("checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
               chk_checks, errors, asserts, timeouts);
      if (errors == 0 && asserts == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
      finish_run();
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         tb_errors++;
         $display("error at %0t: %s expected %0b got %0b", $time, name, expected, actual);
      end
   endtask

   function automatic bus_req_t make_req(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata,
                                         logic [STRB_W-1:0] wstrb);
      bus_req_t req;
      req.valid = 1'b1;
      req.addr = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      return req;
   endfunction

   // drives one or both buses and holds each request until its ready
   task automatic transfer(input logic use_i, input bus_req_t inext, input logic use_d,
                           input bus_req_t dnext);
      logic i_done;
      logic d_done;
      int   waited;
      i_done = ~use_i;
      d_done = ~use_d;
      waited = 0;
      @(negedge clk);
      if (use_i) begin
         ireq = inext;
      end
      if (use_d) begin
         dreq = dnext;
      end
      while (!(i_done && d_done)) begin
         @(negedge clk);
         if (!i_done && iresp.ready) begin
            i_done = 1'b1;
            ireq.valid = 1'b0;
         end
         if (!d_done && dresp.ready) begin
            d_done = 1'b1;
            dreq.valid = 1'b0;
         end
         waited++;
         if (waited > TIMEOUT) begin
            note_timeout("a bus response");
         end
      end
   endtask

   initial begin
      void'($urandom(32'hdc65));
      rst = 1'b1;
      ireq = '0;
      dreq = '0;
      idle = '0;
      repeat (10) @(negedge clk);
      check_flag("o_boot", 1'b1, boot);
      check_flag("o_cpu_reset", 1'b1, cpu_reset);
      rst = 1'b0;

      // copy runs on its own while the processor stays in reset
      cycles = 0;
      while (cpu_reset) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            note_timeout("release of o_cpu_reset after the boot copy");
         end
      end
      check_flag("o_boot", 1'b1, boot);

      // fetches during boot land on the image
      for (int k = 0; k < BOOT_WORDS; k++) begin
         transfer(1'b1, make_req(ADDR_W'(k * 4), '0, '0), 1'b0, idle);
      end

      // full word first so no byte stays unwritten
      for (int k = 0; k < NUM_WR; k++) begin
         waddr[k] = ADDR_W'($urandom_range(16, 255)) << 2;
         transfer(1'b0, idle, 1'b1, make_req(waddr[k], $urandom, '1));
         transfer(1'b0, idle, 1'b1,
                  make_req(waddr[k], $urandom, STRB_W'($urandom_range(1, 15))));
      end
      for (int k = 0; k < NUM_WR; k++) begin
         transfer(1'b1, make_req(ADDR_W'(k * 4), '0, '0), 1'b1, make_req(waddr[k], '0, '0));
      end

      // register reads back 1, a write of 1 ends boot
      transfer(1'b0, idle, 1'b1, make_req(CTRL_ADDR, '0, '0));
      transfer(1'b0, idle, 1'b1, make_req(CTRL_ADDR, 32'h1, '1));
      check_flag("o_boot", 1'b0, boot);
      check_flag("o_cpu_reset", 1'b1, cpu_reset);
      @(negedge clk);
      check_flag("o_cpu_reset", 1'b0, cpu_reset);
      transfer(1'b0, idle, 1'b1, make_req(CTRL_ADDR, '0, '0));

      // data written during boot is now reached at its shifted address
      for (int k = 0; k < NUM_WR; k++) begin
         transfer(1'b1, make_req(waddr[k] + BOOT_BYTE_OFFSET, '0, '0), 1'b1,
                  make_req(waddr[k] + BOOT_BYTE_OFFSET, '0, '0));
      end

      // unshifted map from here on
      for (int k = 0; k < NUM_WR; k++) begin
         transfer(1'b0, idle, 1'b1, make_req(waddr[k], $urandom, '1));
         transfer(1'b1, make_req(waddr[k], '0, '0), 1'b1, make_req(waddr[k], '0, '0));
      end
      for (int k = 0; k < BOOT_WORDS; k++) begin
         transfer(1'b1, make_req(BOOT_BYTE_OFFSET + ADDR_W'(k * 4), '0, '0), 1'b0, idle);
      end

      finish_run();
   end

endmodule

//--- hw/boot/boot.hex
// one 32-bit boot image word per line, words 0 to 15 in order
000010b7
00008093
00002137
ffc10113
00000193
00100213
0040a023
00408093
fff20213
fe021ce3
00000297
01028293
0002a303
00030067
0000006f
00000013

//--- list.f
common/mem_pkg.sv
hw/int_sram.sv
hw/bus_split.sv
hw/bus_merge.sv
hw/boot/boot_ctr.sv
hw/int_mem.sv
verif/int_mem_assert.sv
verif/int_mem_checker.sv
verif/int_mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= int_mem_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
